// File: project.f
trs_bus_pkg.sv
esp_proto_pkg.sv
trs_bus_if.sv
esp_cmd_if.sv
trs_bus_sync.sv
spi_slave.sv
esp_cmd_decoder.sv
shadow_ram.sv
esp_request.sv
trs_bus_drive.sv
trs_io_top.sv
tb_trs_io.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ns
TOP   = tb_trs_io
FLIST = project.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_trs_io.sv
`timescale 1ns/1ns

module tb_trs_io;
  import trs_bus_pkg::*;
  import esp_proto_pkg::*;

  localparam int REQ_PULSE = 50;
  localparam int HALF_SCK  = 12; // clocks per sck half period
  localparam int Z80_HOLD  = 16; // strobe length in clocks
  localparam int N_POKES   = 16;
  localparam int N_WRITES  = 16; // per address group, three groups
  // a 4-byte spi frame is about 800 clocks, the whole run about 110k
  localparam int MAX_CYCLES = 200000;

  logic        clk;
  logic        reset;
  logic        rd_n, wr_n, in_n, out_n;
  logic        sck, cs_n, mosi, esp_done;
  addr_t       a;
  data_t       d_in;
  data_t       d_out;
  logic        d_oe, d_dir, miso, esp_req, wait_req;
  esp_reason_e esp_s;

  // reference model
  data_t model_mem [32768]; // indexed by a[14:0]
  logic  model_full;        // full-address mode
  data_t model_prn_byte;
  data_t model_prn_status;

  int unsigned cycles = 0;

  trs_io_top #(
    .RAM_ADDR_BITS(15),
    .REQ_PULSE(REQ_PULSE),
    .SYNC_STAGES(2)
  ) DUT (
    .clk, .reset, .rd_n, .wr_n, .in_n, .out_n, .sck, .cs_n, .mosi, .esp_done,
    .a, .d_in, .d_out, .d_oe, .d_dir, .miso, .esp_req, .wait_req, .esp_s
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
      abort_run($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(input string name, input logic [15:0] got,
                       input logic [15:0] exp);
    if (got !== exp)
      abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic tick();
    @(posedge clk);
    #1; // drive slot, edge outputs settled
  endtask

  task automatic idle_clocks(input int n);
    repeat (n) tick();
  endtask

  // one mode 0 byte, msb first
  task automatic shift_byte(input data_t tx, output data_t rx);
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      idle_clocks(HALF_SCK);
      rx[i] = miso; // read just before the rise
      sck = 1'b1;
      idle_clocks(HALF_SCK);
      sck = 1'b0;   // slave shifts here
    end
  endtask

  task automatic open_frame();
    cs_n = 1'b0;
    idle_clocks(4);
  endtask

  task automatic close_frame();
    idle_clocks(HALF_SCK);
    cs_n = 1'b1;
    idle_clocks(HALF_SCK); // bit counter clears
  endtask

  // parameterless command, answer rides in the dummy byte
  task automatic ask(input data_t op, output data_t resp);
    data_t junk;
    open_frame();
    shift_byte(op, junk);
    shift_byte(8'h00, resp);
    close_frame();
  endtask

  task automatic send_with_byte(input data_t op, input data_t p);
    data_t junk;
    open_frame();
    shift_byte(op, junk);
    shift_byte(p, junk);
    close_frame();
  endtask

  task automatic poke(input logic [14:0] idx, input data_t val);
    data_t junk;
    open_frame();
    shift_byte(bram_poke, junk);
    shift_byte(idx[7:0], junk);          // lo
    shift_byte({1'b0, idx[14:8]}, junk); // hi
    shift_byte(val, junk);
    close_frame();
  endtask

  task automatic peek(input logic [14:0] idx, output data_t val);
    data_t junk;
    open_frame();
    shift_byte(bram_peek, junk);
    shift_byte(idx[7:0], junk);
    shift_byte({1'b0, idx[14:8]}, junk);
    shift_byte(8'h00, val);
    close_frame();
  endtask

  task automatic mem_read(input addr_t addr, output data_t data);
    a    = addr;
    rd_n = 1'b0;
    repeat (Z80_HOLD) begin
      tick();
      check("wait_req", 16'(wait_req), 16'h0);
    end
    check("d_oe", 16'(d_oe), 16'h1);
    check("d_dir", 16'(d_dir), 16'h0); // toward the z80
    data = d_out;
    rd_n = 1'b1;
    idle_clocks(6); // synchronizer sees the release
  endtask

  task automatic mem_write(input addr_t addr, input data_t data);
    a    = addr;
    d_in = data;
    wr_n = 1'b0;
    repeat (Z80_HOLD) begin
      tick();
      check("wait_req", 16'(wait_req), 16'h0); // memory writes never stall
    end
    check("d_oe", 16'(d_oe), 16'h1);
    check("d_dir", 16'(d_dir), 16'h1);
    wr_n = 1'b1;
    idle_clocks(6);
  endtask

  // model of the write map
  task automatic store_expected(input addr_t addr, input data_t data);
    logic sel;
    sel = model_full ? (addr[15] | addr[14]) : addr[15]; // low 12k is rom
    if (sel) model_mem[addr[14:0]] = data;
  endtask

  task automatic pulse_done();
    esp_done = 1'b1;
    idle_clocks(4);
    esp_done = 1'b0;
    idle_clocks(2);
  endtask

  task automatic await_wait_req(input logic level, input string what);
    int n;
    n = 0;
    while (wait_req !== level) begin
      if (n == 20) abort_run($sformatf("wait_req never went %0b %s", level, what));
      tick();
      n++;
    end
  endtask

  task automatic identity_cmds();
    data_t got;
    ask(get_cookie, got);
    check("cookie", 16'(got), 16'h00af);
    ask(get_version, got);
    check("version", 16'(got), 16'h0003); // 0.3
  endtask

  task automatic poke_readback();
    addr_t addr;
    data_t val;
    data_t got;
    for (int i = 0; i < N_POKES; i++) begin
      addr = 16'h8000 | 16'($urandom_range(32'h7fff));
      val  = 8'($urandom);
      poke(addr[14:0], val);
      model_mem[addr[14:0]] = val;
      peek(addr[14:0], got);
      check("peek_data", 16'(got), 16'(model_mem[addr[14:0]]));
      mem_read(addr, got);
      check("d_out", 16'(got), 16'(model_mem[addr[14:0]]));
    end
  endtask

  // known fill first, so an ignored write shows up
  task automatic write_and_peek(input addr_t addr);
    data_t fill;
    data_t val;
    data_t got;
    fill = 8'($urandom);
    val  = fill ^ 8'($urandom_range(255, 1)); // never equals fill
    poke(addr[14:0], fill);
    model_mem[addr[14:0]] = fill;
    mem_write(addr, val);
    store_expected(addr, val);
    peek(addr[14:0], got);
    check("peek_data", 16'(got), 16'(model_mem[addr[14:0]]));
  endtask

  task automatic z80_write_map();
    addr_t addr;
    for (int i = 0; i < N_WRITES; i++) begin
      do addr = 16'($urandom); while (addr == 16'h37e8); // printer has its own test
      write_and_peek(addr);
    end
    send_with_byte(set_full_addr, 8'h01);
    model_full = 1'b1;
    for (int i = 0; i < N_WRITES; i++)
      write_and_peek(16'h4000 | 16'($urandom_range(32'h3fff)));
    for (int i = 0; i < N_WRITES; i++)
      write_and_peek(16'($urandom_range(32'h2fff))); // rom area
  endtask

  task automatic dbus_access();
    data_t got;
    data_t val;
    a    = 16'($urandom);
    d_in = 8'($urandom);
    ask(dbus_read, got);
    check("dbus_read", 16'(got), 16'(d_in));
    ask(abus_read, got);
    check("abus_read", 16'(got), 16'(a[7:0]));
    // IN from port 31 stalls until the esp puts a byte on the bus
    val  = 8'($urandom);
    a    = {8'($urandom), 8'd31};
    in_n = 1'b0;
    await_wait_req(1'b1, "for IN from port 31");
    check("esp_s", 16'(esp_s), 16'd0); // trs_io_in
    send_with_byte(dbus_write, val);
    check("wait_req", 16'(wait_req), 16'h1);
    pulse_done();
    await_wait_req(1'b0, "after esp_done");
    check("d_out", 16'(d_out), 16'(val));
    check("d_oe", 16'(d_oe), 16'h1);
    check("d_dir", 16'(d_dir), 16'h0);
    in_n = 1'b1;
    idle_clocks(6);
  endtask

  task automatic port_requests();
    data_t      port;
    logic [3:0] reason;
    int         n;
    int         len;
    for (int k = 0; k < 4; k++) begin
      if (k[0]) begin
        port   = {4'hc, 4'($urandom)}; // frehd 0xc0..0xcf
        reason = 4'd3;
      end else begin
        port   = 8'd31;
        reason = 4'd1;
      end
      a     = {8'($urandom), port};
      d_in  = 8'($urandom);
      out_n = 1'b0;
      n = 0;
      while (!esp_req) begin
        if (n == 20) abort_run($sformatf("esp_req did not rise for OUT to port 0x%h", port));
        tick();
        n++;
      end
      len = 0;
      while (esp_req) begin
        check("esp_s", 16'(esp_s), 16'(reason));
        check("wait_req", 16'(wait_req), 16'h1);
        check("d_oe", 16'(d_oe), 16'h1);
        if (len > 2 * REQ_PULSE) abort_run("esp_req stuck high after an OUT");
        tick();
        len++;
      end
      check("esp_req cycles", 16'(len), 16'(REQ_PULSE));
      idle_clocks(10);
      check("wait_req", 16'(wait_req), 16'h1); // z80 still held
      pulse_done();
      await_wait_req(1'b0, "after esp_done");
      out_n = 1'b1;
      idle_clocks(6);
      check("esp_s", 16'(esp_s), 16'd15); // none
    end
  endtask

  task automatic printer_flow();
    data_t got;
    data_t val;
    val = 8'($urandom);
    mem_write(16'h37e8, val);
    model_prn_byte   = val;
    model_prn_status = 8'hf0; // busy until the esp is done
    check("esp_req", 16'(esp_req), 16'h1);
    check("esp_s", 16'(esp_s), 16'd4); // printer_wr
    mem_read(16'h37e8, got);
    check("printer status", 16'(got), 16'(model_prn_status));
    ask(get_printer_byte, got);
    check("printer byte", 16'(got), 16'(model_prn_byte));
    pulse_done();
    model_prn_status = 8'h30;
    check("esp_s", 16'(esp_s), 16'd15);
    mem_read(16'h37e8, got);
    check("printer status", 16'(got), 16'(model_prn_status));
  endtask

  initial begin
    void'($urandom(32'hc7a9dfa4)); // fixed seed
    reset    = 1'b1;
    rd_n     = 1'b1;
    wr_n     = 1'b1;
    in_n     = 1'b1;
    out_n    = 1'b1;
    sck      = 1'b0;
    cs_n     = 1'b1;
    mosi     = 1'b0;
    esp_done = 1'b0;
    a        = '0;
    d_in     = '0;
    model_full       = 1'b0;
    model_prn_byte   = '0;
    model_prn_status = 8'h30; // ready
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    idle_clocks(4);
    check("esp_req", 16'(esp_req), 16'h0);
    check("wait_req", 16'(wait_req), 16'h0);
    check("d_oe", 16'(d_oe), 16'h0);
    check("miso", 16'(miso), 16'h0);
    identity_cmds();
    poke_readback();
    z80_write_map();
    dbus_access();
    port_requests();
    printer_flow();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: trs_io_top.sv
`timescale 1ns/1ns

module trs_io_top #(
  parameter int RAM_ADDR_BITS = 15,
  parameter int REQ_PULSE     = 50,
  parameter int SYNC_STAGES   = 2
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     rd_n,
  input  logic                     wr_n,
  input  logic                     in_n,
  input  logic                     out_n,
  input  logic                     sck,
  input  logic                     cs_n,
  input  logic                     mosi,
  input  logic                     esp_done,
  input  trs_bus_pkg::addr_t       a,
  input  trs_bus_pkg::data_t       d_in,
  output trs_bus_pkg::data_t       d_out,
  output logic                     d_oe,
  output logic                     d_dir,
  output logic                     miso,
  output logic                     esp_req,
  output logic                     wait_req,
  output trs_bus_pkg::esp_reason_e esp_s
);
  import trs_bus_pkg::*;

  trs_bus_if bus ();
  esp_cmd_if cmd ();

  data_t rx_byte, tx_byte, ram_rd_data, peek_data, printer_byte, printer_status;
  logic  rx_valid, ram_rd_valid, peek_valid;

  trs_bus_sync #(.SYNC_STAGES(SYNC_STAGES)) u_sync (
    .clk, .reset, .rd_n, .wr_n, .in_n, .out_n, .a, .d_in, .bus(bus.src)
  );

  spi_slave #(.SYNC_STAGES(SYNC_STAGES)) u_spi (
    .clk, .reset, .sck, .cs_n, .mosi, .tx_byte, .miso, .rx_byte, .rx_valid
  );

  esp_cmd_decoder u_dec (
    .clk, .reset, .rx_byte, .rx_valid, .peek_data, .peek_valid, .printer_byte,
    .bus(bus.snk), .tx_byte, .cmd(cmd.dec)
  );

  shadow_ram #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_ram (
    .clk, .reset, .bus(bus.snk), .cmd(cmd.tgt),
    .ram_rd_data, .peek_data, .ram_rd_valid, .peek_valid
  );

  esp_request #(.REQ_PULSE(REQ_PULSE)) u_req (
    .clk, .reset, .esp_done, .bus(bus.snk), .cmd(cmd.tgt),
    .esp_req, .wait_req, .esp_s, .printer_byte, .printer_status
  );

  trs_bus_drive u_drive (
    .clk, .reset, .bus(bus.snk), .cmd(cmd.tgt), .ram_rd_data, .ram_rd_valid,
    .printer_status, .d_out, .d_oe, .d_dir
  );

endmodule

// File: trs_bus_drive.sv
`timescale 1ns/1ns

module trs_bus_drive (
  input  logic               clk,
  input  logic               reset,
  trs_bus_if.snk             bus,
  esp_cmd_if.tgt             cmd,
  input  trs_bus_pkg::data_t ram_rd_data,
  input  logic               ram_rd_valid,
  input  trs_bus_pkg::data_t printer_status,
  output trs_bus_pkg::data_t d_out,
  output logic               d_oe,
  output logic               d_dir
);
  import trs_bus_pkg::*;
  import esp_proto_pkg::*;

  logic full_addr; // mirror of the ram map mode
  logic prn_addr, mem_rd_sel, io_sel;

  always_ff @(posedge clk) begin
    if (reset) full_addr <= 1'b0;
    else if (cmd.action && cmd.opcode == set_full_addr)
      full_addr <= (cmd.params[0] != 8'h00);
  end

  assign prn_addr   = bus.addr == PRINTER_ADDR;
  assign mem_rd_sel = full_addr ? (bus.addr[15] | bus.addr[14] | (bus.addr < ROM_END))
                                : bus.addr[15];
  assign io_sel = ((bus.addr[7:0] == TRS_IO_PORT) | (bus.addr[7:4] == FREHD_PORT_HI))
                & (bus.io_in | bus.io_out);

  // read data register, ram wins
  always_ff @(posedge clk) begin
    if (ram_rd_valid)
      d_out <= ram_rd_data;
    else if (cmd.action && cmd.opcode == dbus_write)
      d_out <= cmd.params[0];
    else if (bus.access && bus.rd && prn_addr)
      d_out <= printer_status;
  end

  assign d_oe  = io_sel | bus.wr | bus.io_out | (bus.rd & (mem_rd_sel | prn_addr));
  assign d_dir = ~(bus.rd | bus.io_in); // high = toward the board

endmodule

// File: esp_request.sv
`timescale 1ns/1ns

module esp_request #(
  parameter int REQ_PULSE = 50
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      esp_done,
  trs_bus_if.snk                    bus,
  esp_cmd_if.tgt                    cmd,
  output logic                      esp_req,
  output logic                      wait_req,
  output trs_bus_pkg::esp_reason_e  esp_s,
  output trs_bus_pkg::data_t        printer_byte,
  output trs_bus_pkg::data_t        printer_status
);
  import trs_bus_pkg::*;

  localparam int CW = $clog2(REQ_PULSE + 1);

  logic          io_port, frehd_port;
  logic          trs_io_sel_in, trs_io_sel_out, frehd_sel_in, frehd_sel_out;
  logic          prn_sel_wr, esp_sel, start;
  logic          prn_pending;
  logic [2:0]    done_q;
  logic          done_rise;
  logic [CW-1:0] count;

  assign io_port        = bus.addr[7:0] == TRS_IO_PORT;
  assign frehd_port     = bus.addr[7:4] == FREHD_PORT_HI;
  assign trs_io_sel_in  = io_port & bus.io_in;
  assign trs_io_sel_out = io_port & bus.io_out;
  assign frehd_sel_in   = frehd_port & bus.io_in;
  assign frehd_sel_out  = frehd_port & bus.io_out;
  assign prn_sel_wr     = (bus.addr == PRINTER_ADDR) & bus.wr;
  assign esp_sel = trs_io_sel_in | trs_io_sel_out | frehd_sel_in | frehd_sel_out | prn_sel_wr;
  assign start   = bus.access & esp_sel;

  assign done_rise = done_q[2:1] == 2'b01;

  always_ff @(posedge clk) begin
    if (reset) begin
      done_q         <= '0;
      esp_req        <= 1'b0;
      wait_req       <= 1'b0;
      count          <= '0;
      prn_pending    <= 1'b0;
      printer_status <= PRINTER_READY;
    end else begin
      done_q <= {done_q[1:0], esp_done};
      if (start) begin
        esp_req <= 1'b1;   // restarts a running pulse
        count   <= CW'(REQ_PULSE);
        if (prn_sel_wr) begin
          prn_pending    <= 1'b1; // z80 keeps running
          printer_status <= PRINTER_BUSY;
        end else begin
          wait_req <= 1'b1;
        end
      end else begin
        if (count == CW'(1)) esp_req <= 1'b0;
        if (count != '0) count <= count - CW'(1);
        if (done_rise) begin
          wait_req       <= 1'b0;
          prn_pending    <= 1'b0;
          printer_status <= PRINTER_READY;
        end
      end
    end
  end

  // one byte printer buffer
  always_ff @(posedge clk) begin
    if (start && prn_sel_wr) printer_byte <= bus.data;
  end

  // reason code, live from the bus
  always_comb begin
    if (trs_io_sel_in)      esp_s = trs_io_in;
    else if (trs_io_sel_out) esp_s = trs_io_out;
    else if (frehd_sel_in)  esp_s = frehd_in;
    else if (frehd_sel_out) esp_s = frehd_out;
    else if (prn_pending)   esp_s = printer_wr;
    else                    esp_s = none;
  end

  // a pulse without restart ends after REQ_PULSE clocks
  a_req_len: assert property (@(posedge clk) disable iff (reset)
    (esp_req && !start) [*REQ_PULSE] |=> !esp_req);

endmodule

// File: shadow_ram.sv
`timescale 1ns/1ns

module shadow_ram #(
  parameter int RAM_ADDR_BITS = 15
) (
  input  logic               clk,
  input  logic               reset,
  trs_bus_if.snk             bus,
  esp_cmd_if.tgt             cmd,
  output trs_bus_pkg::data_t ram_rd_data,
  output trs_bus_pkg::data_t peek_data,
  output logic               ram_rd_valid,
  output logic               peek_valid
);
  import trs_bus_pkg::*;
  import esp_proto_pkg::*;

  data_t       mem [2**RAM_ADDR_BITS];
  logic        full_addr;
  logic        rd_sel, wr_sel;
  logic        rd_q, peek_q;
  logic [14:0] z80_idx, esp_idx;
  logic [14:0] rd_idx_q;

  // original map is upper 32k only, full mode adds 16k ram plus 12k rom
  assign rd_sel = full_addr ? (bus.addr[15] | bus.addr[14] | (bus.addr < ROM_END))
                            : bus.addr[15];
  assign wr_sel = full_addr ? (bus.addr[15] | bus.addr[14]) : bus.addr[15];

  assign z80_idx = bus.addr[14:0];
  assign esp_idx = {cmd.params[1][6:0], cmd.params[0]};

  always_ff @(posedge clk) begin
    if (reset) begin
      full_addr    <= 1'b0;
      rd_q         <= 1'b0;
      peek_q       <= 1'b0;
      ram_rd_valid <= 1'b0;
      peek_valid   <= 1'b0;
    end else begin
      rd_q         <= bus.access & bus.rd & rd_sel;
      ram_rd_valid <= rd_q;            // 2 clocks after access
      peek_q       <= cmd.action & (cmd.opcode == bram_peek);
      peek_valid   <= peek_q;          // 2 clocks after action
      if (cmd.action && cmd.opcode == set_full_addr)
        full_addr <= (cmd.params[0] != 8'h00);
    end
  end

  always_ff @(posedge clk) begin
    if (bus.access) rd_idx_q <= z80_idx; // hold read index
  end

  // both ports on one array
  always_ff @(posedge clk) begin
    if (bus.access && bus.wr && wr_sel)
      mem[z80_idx[RAM_ADDR_BITS-1:0]] <= bus.data;
    if (cmd.action && cmd.opcode == bram_poke)
      mem[esp_idx[RAM_ADDR_BITS-1:0]] <= cmd.params[2];
    ram_rd_data <= mem[rd_idx_q[RAM_ADDR_BITS-1:0]];
    peek_data   <= mem[esp_idx[RAM_ADDR_BITS-1:0]]; // params held after action
  end

endmodule

// File: esp_cmd_decoder.sv
`timescale 1ns/1ns

module esp_cmd_decoder (
  input  logic               clk,
  input  logic               reset,
  input  trs_bus_pkg::data_t rx_byte,
  input  logic               rx_valid,
  input  trs_bus_pkg::data_t peek_data,
  input  logic               peek_valid,
  input  trs_bus_pkg::data_t printer_byte,
  trs_bus_if.snk             bus,
  output trs_bus_pkg::data_t tx_byte,
  esp_cmd_if.dec             cmd
);
  import trs_bus_pkg::*;
  import esp_proto_pkg::*;

  dec_state_e  state;
  esp_opcode_e op_in;
  esp_opcode_e op_q;
  logic        action_q;
  logic [1:0]  idx;
  logic [1:0]  need;
  logic [1:0]  op_nparams;
  logic        op_known;
  param_arr_t  params_q;
  data_t       resp;

  assign op_in = esp_opcode_e'(rx_byte);

  // parameter count per opcode
  always_comb begin
    op_known   = 1'b1;
    op_nparams = 2'd0;
    case (op_in)
      bram_poke:                 op_nparams = 2'd3; // lo, hi, data
      bram_peek:                 op_nparams = 2'd2; // lo, hi
      dbus_write, set_full_addr: op_nparams = 2'd1;
      get_cookie, get_version, dbus_read,
      abus_read, get_printer_byte: op_nparams = 2'd0;
      default:                   op_known   = 1'b0; // dropped
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= idle;
      op_q     <= get_cookie;
      action_q <= 1'b0;
      idx      <= '0;
      need     <= '0;
    end else begin
      action_q <= 1'b0;
      if (rx_valid) begin
        case (state)
          idle: if (op_known) begin
            op_q <= op_in;
            idx  <= '0;
            need <= op_nparams;
            if (op_nparams == 2'd0) begin
              action_q <= 1'b1; // all parameterless ones answer
              state    <= send_resp;
            end else begin
              state <= read_params;
            end
          end
          read_params: begin
            idx <= idx + 2'd1;
            if (idx == need - 2'd1) begin
              action_q <= 1'b1;
              state    <= (op_q == bram_peek) ? send_resp : idle;
            end
          end
          send_resp: state <= idle; // dummy byte carried the answer
          default:   state <= idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == read_params && rx_valid) params_q[idx] <= rx_byte;
  end

  // response byte picked up by spi_slave at the next byte start
  always_ff @(posedge clk) begin
    if (peek_valid) begin
      resp <= peek_data;
    end else if (state == idle && rx_valid) begin
      case (op_in)
        get_cookie:       resp <= COOKIE;
        get_version:      resp <= VERSION;
        dbus_read:        resp <= bus.data;
        abus_read:        resp <= bus.addr[7:0];
        get_printer_byte: resp <= printer_byte;
        default:          resp <= resp;
      endcase
    end
  end

  assign tx_byte    = resp;
  assign cmd.action = action_q;
  assign cmd.opcode = op_q;
  assign cmd.params = params_q;

  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {idle, read_params, send_resp});

endmodule

// File: spi_slave.sv
`timescale 1ns/1ns

module spi_slave #(
  parameter int SYNC_STAGES = 2
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               sck,
  input  logic               cs_n,
  input  logic               mosi,
  input  trs_bus_pkg::data_t tx_byte,
  output logic               miso,
  output trs_bus_pkg::data_t rx_byte,
  output logic               rx_valid
);
  import trs_bus_pkg::*;

  logic [SYNC_STAGES:0]   sck_q; // one extra stage for edges
  logic [SYNC_STAGES:0]   cs_q;
  logic [SYNC_STAGES-1:0] mosi_q;
  logic       sck_rise, sck_fall;
  logic       cs_act, cs_start;
  logic [2:0] bit_cnt;
  data_t      rx_sr;
  data_t      tx_sr;

  always_ff @(posedge clk) begin
    if (reset) begin
      sck_q  <= '0;
      cs_q   <= '1; // deselected
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[SYNC_STAGES-1:0], sck};
      cs_q   <= {cs_q[SYNC_STAGES-1:0], cs_n};
      mosi_q <= {mosi_q[SYNC_STAGES-2:0], mosi};
    end
  end

  assign sck_rise = sck_q[SYNC_STAGES-1] & ~sck_q[SYNC_STAGES];
  assign sck_fall = ~sck_q[SYNC_STAGES-1] & sck_q[SYNC_STAGES];
  assign cs_act   = ~cs_q[SYNC_STAGES-1];
  assign cs_start = cs_act & cs_q[SYNC_STAGES]; // cs just went low

  // receive side, mode 0 samples on rise
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_act) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) rx_valid <= 1'b1; // eighth bit in
      end
    end
  end

  // payload shifters
  always_ff @(posedge clk) begin
    if (cs_act && sck_rise) begin
      rx_sr <= {rx_sr[6:0], mosi_q[SYNC_STAGES-1]};
      if (bit_cnt == 3'd7) rx_byte <= {rx_sr[6:0], mosi_q[SYNC_STAGES-1]};
    end
    if (cs_start) begin
      tx_sr <= tx_byte; // first msb before first rise
    end else if (cs_act && sck_fall) begin
      // fall after the 8th rise starts the next byte
      if (bit_cnt == 3'd0) tx_sr <= tx_byte;
      else tx_sr <= {tx_sr[6:0], 1'b0};
    end
  end

  assign miso = cs_act ? tx_sr[7] : 1'b0; // quiet when deselected

endmodule

// File: trs_bus_sync.sv
`timescale 1ns/1ns

module trs_bus_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                rd_n,
  input  logic                wr_n,
  input  logic                in_n,
  input  logic                out_n,
  input  trs_bus_pkg::addr_t  a,
  input  trs_bus_pkg::data_t  d_in,
  trs_bus_if.src              bus
);

  logic [3:0] sync_q [SYNC_STAGES]; // {out,in,wr,rd}, active low
  logic [3:0] lvl;
  logic       any_act;
  logic       any_q;
  logic       access_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < SYNC_STAGES; i++) sync_q[i] <= 4'hf; // all idle
      any_q    <= 1'b0;
      access_q <= 1'b0;
    end else begin
      sync_q[0] <= {out_n, in_n, wr_n, rd_n};
      for (int i = 1; i < SYNC_STAGES; i++) sync_q[i] <= sync_q[i-1];
      any_q    <= any_act;
      access_q <= any_act & ~any_q; // rising edge, registered
    end
  end

  assign lvl     = ~sync_q[SYNC_STAGES-1];
  assign any_act = |lvl;

  assign bus.rd     = lvl[0];
  assign bus.wr     = lvl[1];
  assign bus.io_in  = lvl[2];
  assign bus.io_out = lvl[3];
  assign bus.access = access_q;
  assign bus.addr   = a;    // stable for the whole cycle
  assign bus.data   = d_in;

  // one access per strobe, never a level
  a_access_pulse: assert property (@(posedge clk) disable iff (reset)
    access_q |=> !access_q);

endmodule

// File: esp_cmd_if.sv
`timescale 1ns/1ns

interface esp_cmd_if;
  import esp_proto_pkg::*;

  logic        action; // one clock per executed command
  esp_opcode_e opcode; // valid with action
  param_arr_t  params; // valid with action

  modport dec (
    output action, opcode, params
  );

  modport tgt (
    input action, opcode, params
  );

endinterface

// File: trs_bus_if.sv
`timescale 1ns/1ns

interface trs_bus_if;
  import trs_bus_pkg::*;

  addr_t addr;   // raw pins
  data_t data;   // raw pins
  logic  rd;     // synchronized, active high
  logic  wr;
  logic  io_in;
  logic  io_out;
  logic  access; // one clock at start of any strobe

  modport src (
    output addr, data, rd, wr, io_in, io_out, access
  );

  modport snk (
    input addr, data, rd, wr, io_in, io_out, access
  );

endinterface

// File: esp_proto_pkg.sv
package esp_proto_pkg;

  // spi command codes, same numbering as on the esp side
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    bram_poke        = 8'd1,
    bram_peek        = 8'd2,
    dbus_read        = 8'd3,
    dbus_write       = 8'd4,
    set_full_addr    = 8'd14,
    get_version      = 8'd15,
    get_printer_byte = 8'd16,
    abus_read        = 8'd18
  } esp_opcode_e;

  typedef enum logic [1:0] {
    idle,
    read_params,
    send_resp
  } dec_state_e;

  // up to three parameter bytes per command
  typedef trs_bus_pkg::data_t [2:0] param_arr_t;

  localparam trs_bus_pkg::data_t COOKIE        = 8'haf;
  localparam logic [2:0]         VERSION_MAJOR = 3'd0;
  localparam logic [4:0]         VERSION_MINOR = 5'd3;
  localparam trs_bus_pkg::data_t VERSION       = {VERSION_MAJOR, VERSION_MINOR};

endpackage

// File: trs_bus_pkg.sv
package trs_bus_pkg;

  // z80 bus widths
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  data_t; // also used for spi bytes

  // memory map
  localparam addr_t ROM_END      = 16'h3000; // full mode rom below this
  localparam addr_t PRINTER_ADDR = 16'h37e8;

  // i/o ports
  localparam data_t      TRS_IO_PORT   = 8'd31;
  localparam logic [3:0] FREHD_PORT_HI = 4'hc; // ports 0xc0..0xcf

  // printer status as seen by a z80 read of 0x37e8
  localparam data_t PRINTER_READY = 8'h30;
  localparam data_t PRINTER_BUSY  = 8'hf0;

  // why the esp was woken up, shown on esp_s
  typedef enum logic [3:0] {
    trs_io_in  = 4'd0,
    trs_io_out = 4'd1,
    frehd_in   = 4'd2,
    frehd_out  = 4'd3,
    printer_wr = 4'd4,
    none       = 4'd15
  } esp_reason_e;

endpackage
